/* rtl/ccu_pkg.sv */
package ccu_pkg;

  localparam int unsigned NUM_PORTS = 2;

  typedef logic [31:0]                  addr_t;
  typedef logic [31:0]                  data_t;
  typedef logic [NUM_PORTS-1:0]         port_mask_t;
  typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;
  typedef logic [15:0]                  hit_cnt_t;

  // snoop opcodes carried on the AC channel.
  typedef logic [1:0] snoop_op_t;
  localparam snoop_op_t SNOOP_READ_SHARED   = 2'b01;
  localparam snoop_op_t SNOOP_CLEAN_INVALID = 2'b10;

  typedef logic [3:0] lite_addr_t;
  localparam lite_addr_t REG_MASK0 = 4'h0;
  localparam lite_addr_t REG_MASK1 = 4'h4;
  localparam lite_addr_t REG_CTRL  = 4'h8;
  localparam lite_addr_t REG_HITS  = 4'hC;

  // by default each port snoops the other one.
  localparam port_mask_t MASK0_RESET = 2'b10;
  localparam port_mask_t MASK1_RESET = 2'b01;

  localparam logic [1:0] LITE_RESP_OKAY   = 2'b00;
  localparam logic [1:0] LITE_RESP_SLVERR = 2'b10;

  typedef enum logic [2:0] {
    MP_IDLE, MP_SNOOP, MP_MEM_REQ, MP_MEM_WAIT, MP_RESP
  } mp_state_t;

  typedef enum logic [1:0] {
    FAN_IDLE, FAN_AC, FAN_COLLECT
  } fan_state_t;

endpackage

/* rtl/ccu_cfg_regs.sv */
module ccu_cfg_regs import ccu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  lite_addr_t                 awaddr_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  data_t                      wdata_i,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  output logic [1:0]                 bresp_o,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  input  lite_addr_t                 araddr_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output data_t                      rdata_o,
  output logic [1:0]                 rresp_o,
  output port_mask_t [NUM_PORTS-1:0] domain_mask_o,
  output logic                       snoop_en_o,
  input  logic                       hit_inc_i
);

  port_mask_t mask0_q;
  port_mask_t mask1_q;
  logic       snoop_en_q;
  hit_cnt_t   hits_q;
  logic       idle;
  logic       wr_fire;
  logic       rd_fire;
  logic       wr_ok;

  // Only one access is open at a time, and a write wins over a read in the same cycle.
  assign idle      = !bvalid_o && !rvalid_o;
  assign wr_fire   = idle && awvalid_i && wvalid_i;
  assign rd_fire   = idle && arvalid_i && !wr_fire;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;
  assign arready_o = rd_fire;

  // the hit counter is read-only.
  assign wr_ok = awaddr_i inside {REG_MASK0, REG_MASK1, REG_CTRL};

  assign domain_mask_o[0] = mask0_q;
  assign domain_mask_o[1] = mask1_q;
  assign snoop_en_o       = snoop_en_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mask0_q    <= MASK0_RESET;
      mask1_q    <= MASK1_RESET;
      snoop_en_q <= 1'b1;
      hits_q     <= '0;
      bvalid_o   <= 1'b0;
      rvalid_o   <= 1'b0;
    end else begin
      if (wr_fire) begin
        case (awaddr_i)
          REG_MASK0: mask0_q <= wdata_i[NUM_PORTS-1:0];
          REG_MASK1: mask1_q <= wdata_i[NUM_PORTS-1:0];
          REG_CTRL:  snoop_en_q <= wdata_i[0];
          default: ;
        endcase
      end
      // saturates at all ones.
      if (hit_inc_i && hits_q != '1) begin
        hits_q <= hits_q + 1'b1;
      end
      if (wr_fire) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_o <= wr_ok ? LITE_RESP_OKAY : LITE_RESP_SLVERR;
    end
    if (rd_fire) begin
      rresp_o <= LITE_RESP_OKAY;
      case (araddr_i)
        REG_MASK0: rdata_o <= data_t'(mask0_q);
        REG_MASK1: rdata_o <= data_t'(mask1_q);
        REG_CTRL:  rdata_o <= data_t'(snoop_en_q);
        REG_HITS:  rdata_o <= data_t'(hits_q);
        default: begin
          rdata_o <= '0;
          rresp_o <= LITE_RESP_SLVERR;
        end
      endcase
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o);
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o && !rready_i |=> rvalid_o);

endmodule

/* rtl/ccu_arbiter.sv */
module ccu_arbiter import ccu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  port_mask_t req_valid_i,
  output logic       grant_valid_o,
  output port_idx_t  grant_idx_o,
  input  logic       txn_done_i
);

  port_idx_t rr_q;
  port_idx_t pick;

  // search from the pointer upwards; the closest requester wins.
  always_comb begin
    int unsigned cand;
    pick = rr_q;
    for (int k = NUM_PORTS - 1; k >= 0; k--) begin
      cand = (int'(rr_q) + k) % NUM_PORTS;
      if (req_valid_i[cand]) begin
        pick = port_idx_t'(cand);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      grant_valid_o <= 1'b0;
      grant_idx_o   <= '0;
      rr_q          <= '0;
    end else if (!grant_valid_o) begin
      if (|req_valid_i) begin
        grant_valid_o <= 1'b1;
        grant_idx_o   <= pick;
        rr_q          <= port_idx_t'((int'(pick) + 1) % NUM_PORTS);
      end
    end else if (txn_done_i) begin
      grant_valid_o <= 1'b0;
    end
  end

  // The requester holds valid until accepted, so it must still be there when the grant shows.
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(grant_valid_o) |-> req_valid_i[grant_idx_o]);

endmodule

/* rtl/ccu_master_path.sv */
module ccu_master_path import ccu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  port_mask_t                 req_valid_i,
  output port_mask_t                 req_ready_o,
  input  port_mask_t                 req_write_i,
  input  addr_t      [NUM_PORTS-1:0] req_addr_i,
  input  data_t      [NUM_PORTS-1:0] req_wdata_i,
  output port_mask_t                 resp_valid_o,
  input  port_mask_t                 resp_ready_i,
  output data_t      [NUM_PORTS-1:0] resp_rdata_o,
  input  logic                       grant_valid_i,
  input  port_idx_t                  grant_idx_i,
  output logic                       txn_done_o,
  input  port_mask_t [NUM_PORTS-1:0] domain_mask_i,
  input  logic                       snoop_en_i,
  output logic                       hit_inc_o,
  output logic                       snoop_start_o,
  output port_mask_t                 snoop_sel_o,
  output addr_t                      snoop_addr_o,
  output snoop_op_t                  snoop_op_o,
  input  logic                       snoop_done_i,
  input  logic                       snoop_hit_i,
  input  data_t                      snoop_data_i,
  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output logic                       mem_req_write_o,
  output addr_t                      mem_req_addr_o,
  output data_t                      mem_req_wdata_o,
  input  logic                       mem_resp_valid_i,
  input  data_t                      mem_resp_rdata_i
);

  mp_state_t  state_q;
  logic       start_q;
  port_idx_t  idx_q;
  logic       write_q;
  addr_t      addr_q;
  data_t      wdata_q;
  data_t      rdata_q;
  port_mask_t sel_q;
  port_mask_t own_bit;
  port_mask_t eff_mask;
  logic       accept;

  assign accept = state_q == MP_IDLE && grant_valid_i && req_valid_i[grant_idx_i];

  // A requester never snoops itself.
  assign own_bit  = port_mask_t'(1) << grant_idx_i;
  assign eff_mask = snoop_en_i ? (domain_mask_i[grant_idx_i] & ~own_bit) : '0;

  always_comb begin
    req_ready_o  = '0;
    resp_valid_o = '0;
    if (state_q == MP_IDLE && grant_valid_i) begin
      req_ready_o[grant_idx_i] = 1'b1;
    end
    if (state_q == MP_RESP) begin
      resp_valid_o[idx_q] = 1'b1;
    end
  end

  assign resp_rdata_o = {NUM_PORTS{rdata_q}};
  assign txn_done_o   = state_q == MP_RESP && resp_ready_i[idx_q];
  assign hit_inc_o    = state_q == MP_SNOOP && snoop_done_i && !write_q && snoop_hit_i;

  assign snoop_start_o = start_q;
  assign snoop_sel_o   = sel_q;
  assign snoop_addr_o  = addr_q;
  assign snoop_op_o    = write_q ? SNOOP_CLEAN_INVALID : SNOOP_READ_SHARED;

  assign mem_req_valid_o = state_q == MP_MEM_REQ;
  assign mem_req_write_o = write_q;
  assign mem_req_addr_o  = addr_q;
  assign mem_req_wdata_o = wdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= MP_IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state_q)
        MP_IDLE: begin
          if (accept) begin
            if (|eff_mask) begin
              state_q <= MP_SNOOP;
              start_q <= 1'b1;
            end else begin
              state_q <= MP_MEM_REQ;
            end
          end
        end
        MP_SNOOP: begin
          // a write always goes on to memory once the other copies are gone.
          if (snoop_done_i) begin
            state_q <= (!write_q && snoop_hit_i) ? MP_RESP : MP_MEM_REQ;
          end
        end
        MP_MEM_REQ: begin
          if (mem_req_ready_i) begin
            state_q <= MP_MEM_WAIT;
          end
        end
        MP_MEM_WAIT: begin
          if (mem_resp_valid_i) begin
            state_q <= MP_RESP;
          end
        end
        MP_RESP: begin
          if (resp_ready_i[idx_q]) begin
            state_q <= MP_IDLE;
          end
        end
        default: state_q <= MP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      idx_q   <= grant_idx_i;
      write_q <= req_write_i[grant_idx_i];
      addr_q  <= req_addr_i[grant_idx_i];
      wdata_q <= req_wdata_i[grant_idx_i];
      sel_q   <= eff_mask;
    end
    if (hit_inc_o) begin
      rdata_q <= snoop_data_i;
    end else if (state_q == MP_MEM_WAIT && mem_resp_valid_i) begin
      rdata_q <= mem_resp_rdata_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_valid_o && !mem_req_ready_i |=>
      mem_req_valid_o && $stable({mem_req_write_o, mem_req_addr_o, mem_req_wdata_o}));

endmodule

/* rtl/ccu_snoop_fanout.sv */
module ccu_snoop_fanout import ccu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      snoop_start_i,
  input  port_mask_t                snoop_sel_i,
  input  addr_t                     snoop_addr_i,
  input  snoop_op_t                 snoop_op_i,
  output logic                      snoop_done_o,
  output logic                      snoop_hit_o,
  output data_t                     snoop_data_o,
  output port_mask_t                ac_valid_o,
  input  port_mask_t                ac_ready_i,
  output addr_t     [NUM_PORTS-1:0] ac_addr_o,
  output snoop_op_t [NUM_PORTS-1:0] ac_snoop_o,
  input  port_mask_t                cr_valid_i,
  output port_mask_t                cr_ready_o,
  input  port_mask_t                cr_data_xfer_i,
  input  port_mask_t                cd_valid_i,
  output port_mask_t                cd_ready_o,
  input  data_t     [NUM_PORTS-1:0] cd_data_i
);

  fan_state_t state_q;
  port_mask_t ac_pend_q;
  port_mask_t cr_pend_q;
  port_mask_t cd_pend_q;
  logic       hit_q;
  addr_t      addr_q;
  snoop_op_t  op_q;
  port_idx_t  src_q;
  data_t      data_q;

  // the AC pending bits are loaded when a snoop starts and drain in FAN_AC.
  assign ac_valid_o = ac_pend_q;
  assign ac_addr_o  = {NUM_PORTS{addr_q}};
  assign ac_snoop_o = {NUM_PORTS{op_q}};
  assign cr_ready_o = state_q == FAN_COLLECT ? cr_pend_q : '0;
  assign cd_ready_o = state_q == FAN_COLLECT ? cd_pend_q : '0;

  assign snoop_done_o = state_q == FAN_COLLECT && cr_pend_q == '0 && cd_pend_q == '0;
  assign snoop_hit_o  = hit_q;
  assign snoop_data_o = data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= FAN_IDLE;
      ac_pend_q <= '0;
      cr_pend_q <= '0;
      cd_pend_q <= '0;
      hit_q     <= 1'b0;
    end else begin
      case (state_q)
        FAN_IDLE: begin
          if (snoop_start_i) begin
            ac_pend_q <= snoop_sel_i;
            cr_pend_q <= snoop_sel_i;
            cd_pend_q <= '0;
            hit_q     <= 1'b0;
            state_q   <= FAN_AC;
          end
        end
        FAN_AC: begin
          ac_pend_q <= ac_pend_q & ~ac_ready_i;
          if ((ac_pend_q & ~ac_ready_i) == '0) begin
            state_q <= FAN_COLLECT;
          end
        end
        FAN_COLLECT: begin
          // a CR that announces data opens a CD slot on the same port.
          cr_pend_q <= cr_pend_q & ~cr_valid_i;
          cd_pend_q <= (cd_pend_q & ~cd_valid_i) | (cr_pend_q & cr_valid_i & cr_data_xfer_i);
          if (|(cd_pend_q & cd_valid_i)) begin
            hit_q <= 1'b1;
          end
          if (snoop_done_o) begin
            state_q <= FAN_IDLE;
          end
        end
        default: state_q <= FAN_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == FAN_IDLE && snoop_start_i) begin
      addr_q <= snoop_addr_i;
      op_q   <= snoop_op_i;
    end
    // Walk downwards so the lowest supplying port is written last.
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      if (cd_ready_o[i] && cd_valid_i[i] && (!hit_q || port_idx_t'(i) < src_q)) begin
        data_q <= cd_data_i[i];
        src_q  <= port_idx_t'(i);
      end
    end
  end

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_cd_check
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cd_valid_i[i] |-> cd_pend_q[i] || (cr_valid_i[i] && cr_data_xfer_i[i]));
  end

endmodule

/* rtl/ccu_top.sv */
module ccu_top import ccu_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  port_mask_t                req_valid_i,
  output port_mask_t                req_ready_o,
  input  port_mask_t                req_write_i,
  input  addr_t     [NUM_PORTS-1:0] req_addr_i,
  input  data_t     [NUM_PORTS-1:0] req_wdata_i,
  output port_mask_t                resp_valid_o,
  input  port_mask_t                resp_ready_i,
  output data_t     [NUM_PORTS-1:0] resp_rdata_o,
  output port_mask_t                ac_valid_o,
  input  port_mask_t                ac_ready_i,
  output addr_t     [NUM_PORTS-1:0] ac_addr_o,
  output snoop_op_t [NUM_PORTS-1:0] ac_snoop_o,
  input  port_mask_t                cr_valid_i,
  output port_mask_t                cr_ready_o,
  input  port_mask_t                cr_data_xfer_i,
  input  port_mask_t                cd_valid_i,
  output port_mask_t                cd_ready_o,
  input  data_t     [NUM_PORTS-1:0] cd_data_i,
  output logic                      mem_req_valid_o,
  input  logic                      mem_req_ready_i,
  output logic                      mem_req_write_o,
  output addr_t                     mem_req_addr_o,
  output data_t                     mem_req_wdata_o,
  input  logic                      mem_resp_valid_i,
  input  data_t                     mem_resp_rdata_i,
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  lite_addr_t                awaddr_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  input  data_t                     wdata_i,
  output logic                      bvalid_o,
  input  logic                      bready_i,
  output logic [1:0]                bresp_o,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  input  lite_addr_t                araddr_i,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output data_t                     rdata_o,
  output logic [1:0]                rresp_o
);

  logic                       grant_valid;
  port_idx_t                  grant_idx;
  logic                       txn_done;
  port_mask_t [NUM_PORTS-1:0] domain_mask;
  logic                       snoop_en;
  logic                       hit_inc;
  logic                       snoop_start;
  port_mask_t                 snoop_sel;
  addr_t                      snoop_addr;
  snoop_op_t                  snoop_op;
  logic                       snoop_done;
  logic                       snoop_hit;
  data_t                      snoop_data;

  ccu_cfg_regs i_cfg_regs (
    .domain_mask_o (domain_mask),
    .snoop_en_o    (snoop_en),
    .hit_inc_i     (hit_inc),
    .*
  );

  ccu_arbiter i_arbiter (
    .grant_valid_o (grant_valid),
    .grant_idx_o   (grant_idx),
    .txn_done_i    (txn_done),
    .*
  );

  ccu_master_path i_master_path (
    .grant_valid_i (grant_valid),
    .grant_idx_i   (grant_idx),
    .txn_done_o    (txn_done),
    .domain_mask_i (domain_mask),
    .snoop_en_i    (snoop_en),
    .hit_inc_o     (hit_inc),
    .snoop_start_o (snoop_start),
    .snoop_sel_o   (snoop_sel),
    .snoop_addr_o  (snoop_addr),
    .snoop_op_o    (snoop_op),
    .snoop_done_i  (snoop_done),
    .snoop_hit_i   (snoop_hit),
    .snoop_data_i  (snoop_data),
    .*
  );

  ccu_snoop_fanout i_snoop_fanout (
    .snoop_start_i (snoop_start),
    .snoop_sel_i   (snoop_sel),
    .snoop_addr_i  (snoop_addr),
    .snoop_op_i    (snoop_op),
    .snoop_done_o  (snoop_done),
    .snoop_hit_o   (snoop_hit),
    .snoop_data_o  (snoop_data),
    .*
  );

endmodule

/* test/tb_ccu_top.sv */
module tb_ccu_top import ccu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    RESET_CYCLES    = 4;
  localparam int    CYCLES_PER_TEST = 200;
  localparam string STIM_FILE       = "test/ccu_stimulus.txt";

  logic                      clk_i = 1'b0;
  logic                      rst_n_i;
  port_mask_t                req_valid_i;
  port_mask_t                req_ready_o;
  port_mask_t                req_write_i;
  addr_t     [NUM_PORTS-1:0] req_addr_i;
  data_t     [NUM_PORTS-1:0] req_wdata_i;
  port_mask_t                resp_valid_o;
  port_mask_t                resp_ready_i;
  data_t     [NUM_PORTS-1:0] resp_rdata_o;
  port_mask_t                ac_valid_o;
  port_mask_t                ac_ready_i;
  addr_t     [NUM_PORTS-1:0] ac_addr_o;
  snoop_op_t [NUM_PORTS-1:0] ac_snoop_o;
  port_mask_t                cr_valid_i;
  port_mask_t                cr_ready_o;
  port_mask_t                cr_data_xfer_i;
  port_mask_t                cd_valid_i;
  port_mask_t                cd_ready_o;
  data_t     [NUM_PORTS-1:0] cd_data_i;
  logic                      mem_req_valid_o;
  logic                      mem_req_ready_i;
  logic                      mem_req_write_o;
  addr_t                     mem_req_addr_o;
  data_t                     mem_req_wdata_o;
  logic                      mem_resp_valid_i;
  data_t                     mem_resp_rdata_i;
  logic                      awvalid_i;
  logic                      awready_o;
  lite_addr_t                awaddr_i;
  logic                      wvalid_i;
  logic                      wready_o;
  data_t                     wdata_i;
  logic                      bvalid_o;
  logic                      bready_i;
  logic [1:0]                bresp_o;
  logic                      arvalid_i;
  logic                      arready_o;
  lite_addr_t                araddr_i;
  logic                      rvalid_o;
  logic                      rready_i;
  data_t                     rdata_o;
  logic [1:0]                rresp_o;

  integer    seed = 32'h9c72595d;
  int        errors;
  int        n_tests;
  // reply of the snooped caches for the test that is running.
  logic      cur_xfer;
  data_t     cur_cdata;
  // running counters of the models; the stimulus takes differences.
  int        ac_count_of [NUM_PORTS];
  snoop_op_t ac_op_seen [NUM_PORTS];
  addr_t     ac_addr_seen [NUM_PORTS];
  int        ac_total;
  int        ac_at_mem;
  int        mem_count;
  int        mem_wr_count;
  addr_t     wr_addr;
  data_t     wr_data;

  ccu_top u_dut (.*);

  always #50 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  function automatic string op_name(input logic [31:0] op);
    case (op)
      0: return "register read";
      1: return "register write";
      2: return "read";
      3: return "write";
      4: return "read on both ports";
      default: return "unknown";
    endcase
  endfunction

  task automatic count_tests(output int n);
    int    fd;
    string line;
    n = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() >= 2 && line.substr(0, 0) != "#") begin
        n++;
      end
    end
    $fclose(fd);
  endtask

  task automatic reg_write(input lite_addr_t addr, input data_t data, output logic [1:0] resp);
    @(posedge clk_i);
    #5;
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    do begin
      @(posedge clk_i);
    end while (!(awready_o && wready_o));
    #5;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    // bready_i is held high, so the response is taken when it shows.
    do begin
      @(posedge clk_i);
    end while (!bvalid_o);
    resp = bresp_o;
  endtask

  task automatic reg_read(input lite_addr_t addr, output data_t data, output logic [1:0] resp);
    @(posedge clk_i);
    #5;
    arvalid_i = 1'b1;
    araddr_i  = addr;
    do begin
      @(posedge clk_i);
    end while (!arready_o);
    #5;
    arvalid_i = 1'b0;
    do begin
      @(posedge clk_i);
    end while (!rvalid_o);
    data = rdata_o;
    resp = rresp_o;
  endtask

  // Raises the requests of the ports in which and runs until each of them has its response.
  task automatic run_requests(input port_mask_t which, input logic wr, input addr_t addr0,
                              input addr_t addr1, input data_t wdata,
                              output data_t [NUM_PORTS-1:0] rdata, output port_idx_t first);
    port_mask_t pend;
    port_mask_t taken;
    port_mask_t done;
    logic       seen_first;
    rdata      = '0;
    first      = '0;
    seen_first = 1'b0;
    @(posedge clk_i);
    #5;
    req_valid_i    = which;
    req_write_i    = wr ? which : '0;
    req_addr_i[0]  = addr0;
    req_addr_i[1]  = addr1;
    req_wdata_i[0] = wdata;
    req_wdata_i[1] = wdata;
    pend = which;
    while (pend != '0) begin
      @(posedge clk_i);
      taken = req_valid_i & req_ready_o;
      done  = resp_valid_o & resp_ready_i;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (done[p]) begin
          rdata[p] = resp_rdata_o[p];
          if (!seen_first) begin
            first      = port_idx_t'(p);
            seen_first = 1'b1;
          end
        end
      end
      pend = pend & ~done;
      #5;
      req_valid_i = req_valid_i & ~taken;
    end
  endtask

  // both caches answer every snoop with the reply given on the current stimulus line.
  initial begin : cache_model
    port_mask_t hs;
    ac_ready_i     = '1;
    cr_valid_i     = '0;
    cr_data_xfer_i = '0;
    cd_valid_i     = '0;
    cd_data_i      = '0;
    ac_total       = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      ac_count_of[p]  = 0;
      ac_op_seen[p]   = '0;
      ac_addr_seen[p] = '0;
    end
    forever begin
      @(posedge clk_i);
      hs = ac_valid_o & ac_ready_i;
      if (hs != '0) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
          if (hs[p]) begin
            ac_count_of[p]++;
            ac_total++;
            ac_op_seen[p]   = ac_snoop_o[p];
            ac_addr_seen[p] = ac_addr_o[p];
          end
        end
        #5;
        cr_valid_i     = hs;
        cr_data_xfer_i = cur_xfer ? hs : '0;
        do begin
          @(posedge clk_i);
        end while ((cr_ready_o & hs) != hs);
        #5;
        cr_valid_i     = '0;
        cr_data_xfer_i = '0;
        if (cur_xfer) begin
          cd_valid_i = hs;
          for (int p = 0; p < NUM_PORTS; p++) begin
            cd_data_i[p] = cur_cdata;
          end
          do begin
            @(posedge clk_i);
          end while ((cd_ready_o & hs) != hs);
          #5;
          cd_valid_i = '0;
        end
      end
    end
  end

  // Reads return the inverted address after one to three cycles.
  initial begin : memory_model
    int    delay;
    addr_t addr;
    logic  write;
    mem_req_ready_i  = 1'b1;
    mem_resp_valid_i = 1'b0;
    mem_resp_rdata_i = '0;
    mem_count        = 0;
    mem_wr_count     = 0;
    wr_addr          = '0;
    wr_data          = '0;
    ac_at_mem        = 0;
    forever begin
      @(posedge clk_i);
      if (mem_req_valid_o && mem_req_ready_i) begin
        mem_count++;
        addr      = mem_req_addr_o;
        write     = mem_req_write_o;
        ac_at_mem = ac_total;
        if (write) begin
          mem_wr_count++;
          wr_addr = addr;
          wr_data = mem_req_wdata_o;
        end
        delay = 1 + int'($unsigned($random(seed)) % 32'd3);
        repeat (delay - 1) @(posedge clk_i);
        #5;
        mem_resp_valid_i = 1'b1;
        mem_resp_rdata_i = write ? '0 : ~addr;
        @(posedge clk_i);
        #5;
        mem_resp_valid_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    wait (n_tests > 0);
    repeat (n_tests * CYCLES_PER_TEST + RESET_CYCLES) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles",
             n_tests * CYCLES_PER_TEST + RESET_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    int                        fd;
    int                        total;
    int                        n_run;
    int                        errs_before;
    int                        ac_before [NUM_PORTS];
    int                        ac_total_before;
    int                        mem_before;
    int                        wr_before;
    string                     line;
    logic [31:0]               op;
    logic [31:0]               port;
    logic [31:0]               addr;
    logic [31:0]               wdata;
    logic [31:0]               xfer;
    logic [31:0]               cdata;
    logic [31:0]               exp_data;
    logic [31:0]               exp_aux;
    logic [31:0]               exp_ac;
    logic [31:0]               exp_mem;
    data_t                     got;
    logic [1:0]                resp;
    port_mask_t                which;
    snoop_op_t                 exp_op;
    data_t     [NUM_PORTS-1:0] got_data;
    port_idx_t                 first_port;
    rst_n_i      = 1'b0;
    req_valid_i  = '0;
    req_write_i  = '0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    resp_ready_i = '1;
    awvalid_i    = 1'b0;
    awaddr_i     = '0;
    wvalid_i     = 1'b0;
    wdata_i      = '0;
    bready_i     = 1'b1;
    arvalid_i    = 1'b0;
    araddr_i     = '0;
    rready_i     = 1'b1;
    cur_xfer     = 1'b0;
    cur_cdata    = '0;
    errors       = 0;
    n_run        = 0;
    n_tests      = 0;
    count_tests(total);
    if (total == 0) begin
      $display("no tests found: %s is missing or holds no stimulus lines", STIM_FILE);
      errors++;
    end
    n_tests = total;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;
    if (total > 0) begin
      fd = $fopen(STIM_FILE, "r");
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.substr(0, 0) == "#") begin
          continue;
        end
        if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", op, port, addr, wdata, xfer,
                    cdata, exp_data, exp_aux, exp_ac, exp_mem) != 10) begin
          $display("a stimulus line could not be parsed: %s", line);
          errors++;
          continue;
        end
        errs_before     = errors;
        ac_total_before = ac_total;
        mem_before      = mem_count;
        wr_before       = mem_wr_count;
        for (int p = 0; p < NUM_PORTS; p++) begin
          ac_before[p] = ac_count_of[p];
        end
        cur_xfer  = xfer[0];
        cur_cdata = cdata;
        which     = port[0] ? 2'b10 : 2'b01;
        exp_op    = (op == 3) ? SNOOP_CLEAN_INVALID : SNOOP_READ_SHARED;
        case (op)
          0: begin
            reg_read(lite_addr_t'(addr), got, resp);
            check_value("rdata_o", exp_data, got);
            check_value("rresp_o", exp_aux, 32'(resp));
          end
          1: begin
            reg_write(lite_addr_t'(addr), wdata, resp);
            check_value("bresp_o", exp_aux, 32'(resp));
          end
          2: begin
            run_requests(which, 1'b0, addr, addr, wdata, got_data, first_port);
            check_value("resp_rdata_o", exp_data, got_data[port[0]]);
          end
          3: begin
            run_requests(which, 1'b1, addr, addr, wdata, got_data, first_port);
            check_value("mem write count", exp_mem, 32'(mem_wr_count - wr_before));
            check_value("mem_req_addr_o", addr, wr_addr);
            check_value("mem_req_wdata_o", wdata, wr_data);
            // the invalidating snoop must be over before memory sees the write.
            check_value("snoops before mem_req_valid_o", 32'($countones(exp_ac)),
                        32'(ac_at_mem - ac_total_before));
          end
          4: begin
            run_requests(2'b11, 1'b0, addr, wdata, '0, got_data, first_port);
            check_value("first response port", port, 32'(first_port));
            check_value("resp_rdata_o[0]", exp_data, got_data[0]);
            check_value("resp_rdata_o[1]", exp_aux, got_data[1]);
          end
          default: begin
            $display("the stimulus file asks for an unknown operation %0d", op);
            errors++;
          end
        endcase
        if (op >= 2 && op <= 4) begin
          for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("ac_valid_o[%0d] handshakes", p), 32'(exp_ac[p]),
                        32'(ac_count_of[p] - ac_before[p]));
            if (exp_ac[p]) begin
              check_value($sformatf("ac_snoop_o[%0d]", p), 32'(exp_op), 32'(ac_op_seen[p]));
              check_value($sformatf("ac_addr_o[%0d]", p), (op == 4 && p == 0) ? wdata : addr,
                          ac_addr_seen[p]);
            end
          end
          check_value("mem request count", exp_mem, 32'(mem_count - mem_before));
        end
        n_run++;
        $display("test %0d, %s: %s", n_run, op_name(op),
                 (errors == errs_before) ? "ok" : "mismatch");
      end
      $fclose(fd);
    end
    $display("%0d of %0d tests run, %0d checks failed", n_run, total, errors);
    if (errors == 0 && n_run == total && total > 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* test/ccu_stimulus.txt */
# op port addr wdata xfer cdata exp_data exp_aux exp_ac exp_mem (all hex)
# op 0 reg read, 1 reg write, 2 read, 3 write, 4 both ports read (wdata = port 1 addr); exp_aux = resp or port 1 data
0 0 0        0        0 0        2        0        0 0
0 0 4        0        0 0        1        0        0 0
0 0 8        0        0 0        1        0        0 0
0 0 c        0        0 0        0        0        0 0
1 0 c        5        0 0        0        2        0 0
0 0 c        0        0 0        0        0        0 0
2 0 00001000 0        0 0        ffffefff 0        2 1
2 0 00002040 0        1 cafe0001 cafe0001 0        2 0
2 1 00003000 0        1 12345678 12345678 0        1 0
0 0 c        0        0 0        2        0        0 0
3 1 00004000 a5a5a5a5 0 0        0        0        1 1
3 0 00004100 0badf00d 1 11111111 0        0        2 1
1 0 8        0        0 0        0        0        0 0
2 0 00005000 0        1 deadbeef ffffafff 0        0 1
1 0 8        1        0 0        0        0        0 0
1 0 4        0        0 0        0        0        0 0
2 1 00006000 0        1 deadbeef ffff9fff 0        0 1
0 0 4        0        0 0        0        0        0 0
1 0 4        1        0 0        0        0        0 0
0 0 c        0        0 0        2        0        0 0
4 0 00007000 00007400 0 0        ffff8fff ffff8bff 3 2
4 0 00008000 00008800 0 0        ffff7fff ffff77ff 3 2

/* vlog.f */
rtl/ccu_pkg.sv
rtl/ccu_cfg_regs.sv
rtl/ccu_arbiter.sv
rtl/ccu_master_path.sv
rtl/ccu_snoop_fanout.sv
rtl/ccu_top.sv
test/tb_ccu_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_ccu_top -f vlog.f -o sim_ccu || exit 1
out=$(./obj_dir/sim_ccu)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Test passed" && exit 0 || exit 1
